// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] word_t;   // pipeline data word
    typedef logic [3:0]  strb_t;   // byte mask, doubles as access size

    // access size patterns, before the shift into the byte lane
    localparam strb_t STRB_BYTE = 4'b0001;
    localparam strb_t STRB_HALF = 4'b0011;
    localparam strb_t STRB_WORD = 4'b1111;

    // default geometry: 64 sets, 16 words per line
    localparam int DEF_INDEX_WIDTH       = 6;
    localparam int DEF_WORD_OFFSET_WIDTH = 4;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,      // refill read outstanding
        REFILL,
        WAIT_WB    // wait for the write-back machine, then answer
    } ctrl_state_e;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_WRITE,
        WB_DONE
    } wb_state_e;

endpackage

// ==== design/dcache_tag_store.sv ====
`timescale 1ns/1ps

module dcache_tag_store #(
    parameter int  INDEX_WIDTH       = 6,
    parameter int  WORD_OFFSET_WIDTH = 4,
    localparam int TAG_WIDTH         = 30 - INDEX_WIDTH - WORD_OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [INDEX_WIDTH-1:0] i_rd_index,
    input  logic [TAG_WIDTH-1:0]   i_lookup_tag,
    input  logic [INDEX_WIDTH-1:0] i_wr_index,
    input  logic [1:0]             i_tag_we,
    input  logic [TAG_WIDTH-1:0]   i_wr_tag,
    input  logic [1:0]             i_dirty_set,
    input  logic [1:0]             i_dirty_clr,
    input  logic                   i_lru_we,
    input  logic                   i_lru_way,
    output logic [1:0]             o_hit,
    output logic                   o_hit_way,
    output logic                   o_victim_way,
    output logic                   o_victim_dirty,
    output logic [TAG_WIDTH-1:0]   o_victim_tag
);
    localparam int SETS = 1 << INDEX_WIDTH;

    logic [TAG_WIDTH-1:0]   tags [2][SETS];
    logic [1:0][SETS-1:0]   valid_q;
    logic [1:0][SETS-1:0]   dirty_q;
    logic [SETS-1:0]        lru_q;         // most recently used way per set
    logic [INDEX_WIDTH-1:0] rd_index_q;

    // registered read index, so writes at the accept edge are seen in lookup
    always_ff @(posedge clk) begin
        rd_index_q <= i_rd_index;
        for (int w = 0; w < 2; w++) begin
            if (i_tag_we[w]) begin
                tags[w][i_wr_index] <= i_wr_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_tag_we[w]) begin
                    valid_q[w][i_wr_index] <= 1'b1;
                end
                if (i_dirty_set[w]) begin
                    dirty_q[w][i_wr_index] <= 1'b1;
                end else if (i_dirty_clr[w]) begin
                    dirty_q[w][i_wr_index] <= 1'b0;
                end
            end
            if (i_lru_we) begin
                lru_q[i_wr_index] <= i_lru_way;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            o_hit[w] = valid_q[w][rd_index_q] && (tags[w][rd_index_q] == i_lookup_tag);
        end
    end

    assign o_hit_way    = o_hit[1];
    assign o_victim_way = ~lru_q[rd_index_q];   // replace the least recently used way

    // an invalid way never needs a write-back
    assign o_victim_dirty = valid_q[o_victim_way][rd_index_q] & dirty_q[o_victim_way][rd_index_q];
    assign o_victim_tag   = tags[o_victim_way][rd_index_q];

endmodule

// ==== design/dcache_data_store.sv ====
`timescale 1ns/1ps

module dcache_data_store #(
    parameter int  INDEX_WIDTH       = 6,
    parameter int  WORD_OFFSET_WIDTH = 4,
    localparam int LINE_BYTES        = 4 << WORD_OFFSET_WIDTH,
    localparam int LINE_BITS         = 8 * LINE_BYTES
) (
    input  logic                   clk,
    input  logic [INDEX_WIDTH-1:0] i_rd_index,
    input  logic [INDEX_WIDTH-1:0] i_wr_index,
    input  logic [1:0]             i_way_we,
    input  logic                   i_refill,
    input  logic [LINE_BITS-1:0]   i_refill_line,
    input  dcache_pkg::addr_t      i_addr,
    input  dcache_pkg::word_t      i_wdata,
    input  dcache_pkg::strb_t      i_wstrb,
    input  logic                   i_signed_ext,
    input  logic                   i_read_way,
    output logic [LINE_BITS-1:0]   o_victim_line,
    output dcache_pkg::word_t      o_rdata
);
    import dcache_pkg::*;

    localparam int SETS  = 1 << INDEX_WIDTH;
    localparam int WORDS = 1 << WORD_OFFSET_WIDTH;

    logic [LINE_BITS-1:0]         lines [2][SETS];
    logic [INDEX_WIDTH-1:0]       rd_index_q;
    logic [LINE_BITS-1:0]         rd_line;
    logic [WORD_OFFSET_WIDTH-1:0] word_off;
    strb_t                        lane_strb;
    word_t                        lane_data;
    logic [LINE_BYTES-1:0]        byte_en;
    logic [LINE_BITS-1:0]         wr_line;
    word_t                        rd_word;
    logic [7:0]                   rd_byte;
    logic [15:0]                  rd_half;

    assign word_off = i_addr[WORD_OFFSET_WIDTH+1:2];

    // store value arrives in the low bits, move it to its byte lane
    assign lane_strb = i_wstrb << i_addr[1:0];
    assign lane_data = i_wdata << {i_addr[1:0], 3'b000};

    // refill writes the whole line, a store only its own bytes
    assign byte_en = i_refill ? {LINE_BYTES{1'b1}}
                              : {{(LINE_BYTES-4){1'b0}}, lane_strb} << {word_off, 2'b00};
    assign wr_line = i_refill ? i_refill_line : {WORDS{lane_data}};

    always_ff @(posedge clk) begin
        rd_index_q <= i_rd_index;
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (i_way_we[w] && byte_en[b]) begin
                    lines[w][i_wr_index][8*b +: 8] <= wr_line[8*b +: 8];
                end
            end
        end
    end

    assign rd_line       = lines[i_read_way][rd_index_q];
    assign o_victim_line = rd_line;     // read way is the victim during a miss

    assign rd_word = rd_line[32*word_off +: 32];
    assign rd_byte = rd_word[8*i_addr[1:0] +: 8];
    assign rd_half = rd_word[16*i_addr[1] +: 16];

    // size from the strobe, sign from the request
    always_comb begin
        case (i_wstrb)
            STRB_BYTE: o_rdata = {{24{i_signed_ext & rd_byte[7]}}, rd_byte};
            STRB_HALF: o_rdata = {{16{i_signed_ext & rd_half[15]}}, rd_half};
            default:   o_rdata = rd_word;
        endcase
    end

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int  INDEX_WIDTH       = 6,
    parameter int  WORD_OFFSET_WIDTH = 4,
    localparam int OFFSET_WIDTH      = WORD_OFFSET_WIDTH + 2,
    localparam int TAG_WIDTH         = 32 - OFFSET_WIDTH - INDEX_WIDTH,
    localparam int LINE_BITS         = 32 << WORD_OFFSET_WIDTH
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_rvalid,
    input  logic                 i_wvalid,
    input  logic                 i_req_write,
    input  dcache_pkg::addr_t    i_req_addr,
    input  logic [1:0]           i_hit,
    input  logic                 i_hit_way,
    input  logic                 i_victim_way,
    input  logic                 i_victim_dirty,
    input  logic [TAG_WIDTH-1:0] i_victim_tag,
    input  logic [LINE_BITS-1:0] i_victim_line,
    input  logic                 i_mem_rready,
    input  logic                 i_mem_wready,
    output logic                 o_accept,
    output logic                 o_idle,
    output logic                 o_rready,
    output logic                 o_wready,
    output logic [1:0]           o_tag_we,
    output logic [1:0]           o_dirty_set,
    output logic [1:0]           o_dirty_clr,
    output logic                 o_lru_we,
    output logic                 o_lru_way,
    output logic [1:0]           o_way_we,
    output logic                 o_refill,
    output logic                 o_read_way,
    output logic                 o_mem_rvalid,
    output dcache_pkg::addr_t    o_mem_raddr,
    output logic                 o_mem_wvalid,
    output dcache_pkg::addr_t    o_mem_waddr,
    output logic [LINE_BITS-1:0] o_mem_wdata
);
    import dcache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    wb_state_e   wb_state;
    wb_state_e   wb_state_nxt;
    logic        req_valid;
    logic        answer;
    logic        wb_launch;
    logic        wb_clear;
    logic        miss_way_q;   // victim way, held for the whole miss

    assign req_valid = i_rvalid | i_wvalid;
    assign o_idle    = (state == IDLE);
    assign o_rready  = answer & ~i_req_write;
    assign o_wready  = answer & i_req_write;
    assign o_accept  = req_valid & (o_idle | answer);   // answer cycle takes the next request

    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = {i_req_addr[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign o_mem_wvalid = (wb_state == WB_WRITE);

    always_comb begin
        state_nxt   = state;
        answer      = 1'b0;
        wb_launch   = 1'b0;
        wb_clear    = 1'b0;
        o_tag_we    = 2'b00;
        o_dirty_set = 2'b00;
        o_dirty_clr = 2'b00;
        o_lru_we    = 1'b0;
        o_lru_way   = miss_way_q;
        o_way_we    = 2'b00;
        o_refill    = 1'b0;
        o_read_way  = miss_way_q;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (|i_hit) begin
                    answer     = 1'b1;
                    o_read_way = i_hit_way;
                    o_lru_we   = 1'b1;
                    o_lru_way  = i_hit_way;
                    if (i_req_write) begin
                        o_way_we[i_hit_way]    = 1'b1;
                        o_dirty_set[i_hit_way] = 1'b1;
                    end
                    state_nxt = req_valid ? LOOKUP : IDLE;
                end else begin
                    o_read_way = i_victim_way;   // victim line into the write-back buffer
                    wb_launch  = 1'b1;
                    state_nxt  = MISS;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                o_tag_we[miss_way_q] = 1'b1;
                o_way_we[miss_way_q] = 1'b1;
                o_refill             = 1'b1;
                o_lru_we             = 1'b1;
                if (i_req_write) begin
                    o_dirty_set[miss_way_q] = 1'b1;
                end else begin
                    o_dirty_clr[miss_way_q] = 1'b1;
                end
                state_nxt = WAIT_WB;
            end
            WAIT_WB: begin
                if (wb_state == WB_DONE) begin
                    answer               = 1'b1;
                    wb_clear             = 1'b1;
                    o_way_we[miss_way_q] = i_req_write;   // store bytes onto the fresh line
                    state_nxt            = req_valid ? LOOKUP : IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // write-back runs beside the refill, clean victims skip the bus
    always_comb begin
        wb_state_nxt = wb_state;
        case (wb_state)
            WB_IDLE: begin
                if (wb_launch) begin
                    wb_state_nxt = i_victim_dirty ? WB_WRITE : WB_DONE;
                end
            end
            WB_WRITE: begin
                if (i_mem_wready) begin
                    wb_state_nxt = WB_DONE;
                end
            end
            WB_DONE: begin
                if (wb_clear) begin
                    wb_state_nxt = WB_IDLE;
                end
            end
            default: wb_state_nxt = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            wb_state <= WB_IDLE;
        end else begin
            state    <= state_nxt;
            wb_state <= wb_state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_launch) begin
            miss_way_q  <= i_victim_way;
            o_mem_waddr <= {i_victim_tag, i_req_addr[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH],
                            {OFFSET_WIDTH{1'b0}}};
            o_mem_wdata <= i_victim_line;
        end
    end

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int  INDEX_WIDTH       = dcache_pkg::DEF_INDEX_WIDTH,
    parameter int  WORD_OFFSET_WIDTH = dcache_pkg::DEF_WORD_OFFSET_WIDTH,
    localparam int OFFSET_WIDTH      = WORD_OFFSET_WIDTH + 2,
    localparam int TAG_WIDTH         = 32 - OFFSET_WIDTH - INDEX_WIDTH,
    localparam int LINE_BITS         = 32 << WORD_OFFSET_WIDTH
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_rvalid,
    input  logic                 i_wvalid,
    input  dcache_pkg::addr_t    i_addr,
    input  dcache_pkg::word_t    i_wdata,
    input  dcache_pkg::strb_t    i_wstrb,
    input  logic                 i_signed_ext,
    output logic                 o_rready,
    output dcache_pkg::word_t    o_rdata,
    output logic                 o_wready,
    output logic                 o_idle,
    output logic                 o_mem_rvalid,
    input  logic                 i_mem_rready,
    output dcache_pkg::addr_t    o_mem_raddr,
    input  logic [LINE_BITS-1:0] i_mem_rdata,
    output logic                 o_mem_wvalid,
    input  logic                 i_mem_wready,
    output dcache_pkg::addr_t    o_mem_waddr,
    output logic [LINE_BITS-1:0] o_mem_wdata
);
    import dcache_pkg::*;

    // request buffer
    addr_t                  req_addr;
    word_t                  req_wdata;
    strb_t                  req_wstrb;
    logic                   req_signed;
    logic                   req_write;

    logic [LINE_BITS-1:0]   refill_buf;
    logic                   accept;
    logic [INDEX_WIDTH-1:0] req_index;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [TAG_WIDTH-1:0]   req_tag;

    logic [1:0]             hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [TAG_WIDTH-1:0]   victim_tag;
    logic [LINE_BITS-1:0]   victim_line;
    logic [1:0]             tag_we;
    logic [1:0]             dirty_set;
    logic [1:0]             dirty_clr;
    logic                   lru_we;
    logic                   lru_way;
    logic [1:0]             way_we;
    logic                   refill;
    logic                   read_way;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr   <= i_addr;
            req_wdata  <= i_wdata;
            req_wstrb  <= i_wstrb;
            req_signed <= i_signed_ext;
            req_write  <= i_wvalid;
        end
        if (o_mem_rvalid && i_mem_rready) begin
            refill_buf <= i_mem_rdata;   // line is only on the bus in the handshake cycle
        end
    end

    assign req_index = req_addr[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH];
    assign req_tag   = req_addr[31 -: TAG_WIDTH];
    // arrays look up the new index at acceptance, else keep the current one
    assign rd_index  = accept ? i_addr[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH] : req_index;

    dcache_tag_store #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_tag_store (
        .clk            (clk),
        .rstn           (rstn),
        .i_rd_index     (rd_index),
        .i_lookup_tag   (req_tag),
        .i_wr_index     (req_index),
        .i_tag_we       (tag_we),
        .i_wr_tag       (req_tag),
        .i_dirty_set    (dirty_set),
        .i_dirty_clr    (dirty_clr),
        .i_lru_we       (lru_we),
        .i_lru_way      (lru_way),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag)
    );

    dcache_data_store #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_data_store (
        .clk           (clk),
        .i_rd_index    (rd_index),
        .i_wr_index    (req_index),
        .i_way_we      (way_we),
        .i_refill      (refill),
        .i_refill_line (refill_buf),
        .i_addr        (req_addr),
        .i_wdata       (req_wdata),
        .i_wstrb       (req_wstrb),
        .i_signed_ext  (req_signed),
        .i_read_way    (read_way),
        .o_victim_line (victim_line),
        .o_rdata       (o_rdata)
    );

    dcache_ctrl #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_rvalid       (i_rvalid),
        .i_wvalid       (i_wvalid),
        .i_req_write    (req_write),
        .i_req_addr     (req_addr),
        .i_hit          (hit),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .i_victim_line  (victim_line),
        .i_mem_rready   (i_mem_rready),
        .i_mem_wready   (i_mem_wready),
        .o_accept       (accept),
        .o_idle         (o_idle),
        .o_rready       (o_rready),
        .o_wready       (o_wready),
        .o_tag_we       (tag_we),
        .o_dirty_set    (dirty_set),
        .o_dirty_clr    (dirty_clr),
        .o_lru_we       (lru_we),
        .o_lru_way      (lru_way),
        .o_way_we       (way_we),
        .o_refill       (refill),
        .o_read_way     (read_way),
        .o_mem_rvalid   (o_mem_rvalid),
        .o_mem_raddr    (o_mem_raddr),
        .o_mem_wvalid   (o_mem_wvalid),
        .o_mem_waddr    (o_mem_waddr),
        .o_mem_wdata    (o_mem_wdata)
    );

endmodule

// ==== dv/dcache_mem_model.sv ====
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int LINE_BITS = 512
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_rvalid,
    input  logic [31:0]          i_raddr,
    output logic                 o_rready,
    output logic [LINE_BITS-1:0] o_rdata,
    input  logic                 i_wvalid,
    input  logic [31:0]          i_waddr,
    input  logic [LINE_BITS-1:0] i_wdata,
    output logic                 o_wready
);
    localparam int WORDS     = LINE_BITS / 32;
    localparam int LOG_DEPTH = 16;

    logic [31:0]          wb_addr [LOG_DEPTH];   // write-back log, oldest first
    logic [LINE_BITS-1:0] wb_line [LOG_DEPTH];
    int                   wb_count;
    int                   rd_count;              // refill reads served

    // rule content, unless the line came back through a write-back
    function automatic logic [LINE_BITS-1:0] line_at(input logic [31:0] base);
        logic [LINE_BITS-1:0] line;
        logic [31:0]          a;
        for (int k = 0; k < WORDS; k++) begin
            a = base + 4 * k;
            line[32*k +: 32] = {2'b00, a[31:2]} ^ 32'h5a5a_0000;
        end
        for (int i = 0; i < wb_count; i++) begin
            if (wb_addr[i] == base) begin
                line = wb_line[i];   // latest one wins
            end
        end
        return line;
    endfunction

    initial begin
        int rd_wait;
        int wr_wait;
        o_rready = 1'b0;
        o_wready = 1'b0;
        o_rdata  = '0;
        rd_count = 0;
        wb_count = 0;
        rd_wait  = $urandom(32'hf444_31a0) % 6;
        wr_wait  = $urandom % 6;
        forever begin
            @(posedge clk);
            o_rready <= 1'b0;
            o_wready <= 1'b0;
            // write side first so a refill in the same cycle sees the new line
            if (rstn && i_wvalid && !o_wready) begin
                if (wr_wait == 0) begin
                    o_wready <= 1'b1;
                    if (wb_count < LOG_DEPTH) begin
                        wb_addr[wb_count] = i_waddr;
                        wb_line[wb_count] = i_wdata;
                        wb_count++;
                    end
                    wr_wait = $urandom % 6;
                end else begin
                    wr_wait--;
                end
            end
            if (rstn && i_rvalid && !o_rready) begin
                if (rd_wait == 0) begin
                    o_rready <= 1'b1;
                    o_rdata  <= line_at(i_raddr);
                    rd_count++;
                    rd_wait = $urandom % 6;
                end else begin
                    rd_wait--;
                end
            end
        end
    end

endmodule

// ==== dv/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int LINE_BITS   = 32 << DEF_WORD_OFFSET_WIDTH;
    localparam int MAX_ENTRIES = 32;
    localparam int CLK_PERIOD  = 4;

    logic                 clk;
    logic                 rstn;
    logic                 rvalid;
    logic                 wvalid;
    addr_t                addr;
    word_t                wdata;
    strb_t                wstrb;
    logic                 signed_ext;
    logic                 rready;
    word_t                rdata;
    logic                 wready;
    logic                 idle;
    logic                 mem_rvalid;
    logic                 mem_rready;
    addr_t                mem_raddr;
    logic [LINE_BITS-1:0] mem_rdata;
    logic                 mem_wvalid;
    logic                 mem_wready;
    addr_t                mem_waddr;
    logic [LINE_BITS-1:0] mem_wdata;

    // stimulus table
    logic  tbl_write  [MAX_ENTRIES];
    addr_t tbl_addr   [MAX_ENTRIES];
    word_t tbl_wdata  [MAX_ENTRIES];
    strb_t tbl_strb   [MAX_ENTRIES];
    logic  tbl_signed [MAX_ENTRIES];
    word_t tbl_expect [MAX_ENTRIES];
    int    tbl_refill [MAX_ENTRIES];   // refill reads this entry causes
    int    num_entries;
    int    errors;
    int    checks;
    int    reads_seen;

    dcache_top dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (rvalid),
        .i_wvalid     (wvalid),
        .i_addr       (addr),
        .i_wdata      (wdata),
        .i_wstrb      (wstrb),
        .i_signed_ext (signed_ext),
        .o_rready     (rready),
        .o_rdata      (rdata),
        .o_wready     (wready),
        .o_idle       (idle),
        .o_mem_rvalid (mem_rvalid),
        .i_mem_rready (mem_rready),
        .o_mem_raddr  (mem_raddr),
        .i_mem_rdata  (mem_rdata),
        .o_mem_wvalid (mem_wvalid),
        .i_mem_wready (mem_wready),
        .o_mem_waddr  (mem_waddr),
        .o_mem_wdata  (mem_wdata)
    );

    dcache_mem_model #(
        .LINE_BITS (LINE_BITS)
    ) u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .i_rvalid (mem_rvalid),
        .i_raddr  (mem_raddr),
        .o_rready (mem_rready),
        .o_rdata  (mem_rdata),
        .i_wvalid (mem_wvalid),
        .i_waddr  (mem_waddr),
        .i_wdata  (mem_wdata),
        .o_wready (mem_wready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_entry(input logic write, input addr_t a, input word_t d, input strb_t s,
                             input logic sx, input word_t exp, input int refill);
        tbl_write[num_entries]  = write;
        tbl_addr[num_entries]   = a;
        tbl_wdata[num_entries]  = d;
        tbl_strb[num_entries]   = s;
        tbl_signed[num_entries] = sx;
        tbl_expect[num_entries] = exp;
        tbl_refill[num_entries] = refill;
        num_entries++;
    endtask

    task automatic present_entry(input int k);
        rvalid     <= !tbl_write[k];
        wvalid     <= tbl_write[k];
        addr       <= tbl_addr[k];
        wdata      <= tbl_wdata[k];
        wstrb      <= tbl_strb[k];
        signed_ext <= tbl_signed[k];
    endtask

    task automatic check_answer(input int k);
        int reads;
        reads = u_mem.rd_count;
        checks++;
        assert (wready == tbl_write[k]) else begin
            errors++;
            $display("Error at %0t: entry %0d answered as the wrong operation", $time, k);
        end
        if (!tbl_write[k]) begin
            assert (rdata == tbl_expect[k]) else begin
                errors++;
                $display("Error at %0t: entry %0d read %h, expected %h",
                         $time, k, rdata, tbl_expect[k]);
            end
        end
        assert (reads - reads_seen == tbl_refill[k]) else begin
            errors++;
            $display("Error at %0t: entry %0d made %0d refill reads, expected %0d",
                     $time, k, reads - reads_seen, tbl_refill[k]);
        end
        reads_seen = reads;
    endtask

    initial begin
        int   sent;
        int   done;
        logic take;
        num_entries = 0;
        errors      = 0;
        checks      = 0;
        reads_seen  = 0;
        rstn        = 1'b0;
        rvalid      = 1'b0;
        wvalid      = 1'b0;
        addr        = '0;
        wdata       = '0;
        wstrb       = STRB_WORD;
        signed_ext  = 1'b0;

        // first miss, then hits streaming in the same line
        add_entry(0, 32'h0000_0100, 0, STRB_WORD, 0, 32'h5a5a_0040, 1);
        add_entry(0, 32'h0000_0104, 0, STRB_WORD, 0, 32'h5a5a_0041, 0);
        add_entry(0, 32'h0000_0108, 0, STRB_WORD, 0, 32'h5a5a_0042, 0);
        add_entry(0, 32'h0000_013c, 0, STRB_WORD, 0, 32'h5a5a_004f, 0);
        // zero and sign extension of word 0x5a5a8080
        add_entry(0, 32'h0002_0200, 0, STRB_BYTE, 0, 32'h0000_0080, 1);
        add_entry(0, 32'h0002_0200, 0, STRB_BYTE, 1, 32'hffff_ff80, 0);
        add_entry(0, 32'h0002_0200, 0, STRB_HALF, 0, 32'h0000_8080, 0);
        add_entry(0, 32'h0002_0200, 0, STRB_HALF, 1, 32'hffff_8080, 0);
        add_entry(0, 32'h0002_0201, 0, STRB_BYTE, 1, 32'hffff_ff80, 0);
        add_entry(0, 32'h0002_0202, 0, STRB_HALF, 1, 32'h0000_5a5a, 0);
        // store hit, then store miss and a half-word merge
        add_entry(1, 32'h0002_0202, 32'h0000_00a5, STRB_BYTE, 0, 0, 0);
        add_entry(0, 32'h0002_0200, 0, STRB_WORD, 0, 32'h5aa5_8080, 0);
        add_entry(1, 32'h0000_0301, 32'h0000_003c, STRB_BYTE, 0, 0, 1);
        add_entry(0, 32'h0000_0300, 0, STRB_WORD, 0, 32'h5a5a_3cc0, 0);
        add_entry(1, 32'h0000_0302, 32'h0000_beef, STRB_HALF, 0, 0, 0);
        add_entry(0, 32'h0000_0302, 0, STRB_HALF, 1, 32'hffff_beef, 0);
        // dirty line 0x1500 in set 20 gets evicted by the third tag
        add_entry(1, 32'h0000_1508, 32'hcafe_f00d, STRB_WORD, 0, 0, 1);
        add_entry(0, 32'h0000_2500, 0, STRB_WORD, 0, 32'h5a5a_0940, 1);
        add_entry(0, 32'h0000_3500, 0, STRB_WORD, 0, 32'h5a5a_0d40, 1);
        add_entry(0, 32'h0000_1508, 0, STRB_WORD, 0, 32'hcafe_f00d, 1);
        add_entry(0, 32'h0000_1504, 0, STRB_WORD, 0, 32'h5a5a_0541, 0);
        // clean 0x3500 line goes without a write-back
        add_entry(0, 32'h0000_2500, 0, STRB_WORD, 0, 32'h5a5a_0940, 1);
        // LRU order A B A C A B in set 30
        add_entry(0, 32'h0000_4780, 0, STRB_WORD, 0, 32'h5a5a_11e0, 1);
        add_entry(0, 32'h0000_5780, 0, STRB_WORD, 0, 32'h5a5a_15e0, 1);
        add_entry(0, 32'h0000_4780, 0, STRB_WORD, 0, 32'h5a5a_11e0, 0);
        add_entry(0, 32'h0000_6780, 0, STRB_WORD, 0, 32'h5a5a_19e0, 1);
        add_entry(0, 32'h0000_4780, 0, STRB_WORD, 0, 32'h5a5a_11e0, 0);
        add_entry(0, 32'h0000_5780, 0, STRB_WORD, 0, 32'h5a5a_15e0, 1);

        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        checks++;
        assert (idle && !mem_rvalid && !mem_wvalid) else begin
            errors++;
            $display("Error at %0t: not idle after reset, or memory valid raised", $time);
        end

        @(posedge clk);
        present_entry(0);
        sent = 0;
        done = 0;
        while (done < num_entries) begin
            @(negedge clk);
            if (rready || wready) begin
                check_answer(done);
                done++;
            end
            // request on the inputs is taken at the next edge
            take = (rvalid || wvalid) && (idle || rready || wready);
            @(posedge clk);
            if (take) begin
                sent++;
                if (sent < num_entries) begin
                    present_entry(sent);
                end else begin
                    rvalid <= 1'b0;
                    wvalid <= 1'b0;
                end
            end
        end

        checks++;
        assert (u_mem.wb_count == 1 && u_mem.wb_addr[0] == 32'h0000_1500) else begin
            errors++;
            $display("Error at %0t: %0d write-backs logged, first at %h, expected one at 1500",
                     $time, u_mem.wb_count, u_mem.wb_addr[0]);
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog allows 64 cycles per table entry
    initial begin
        @(posedge rstn);
        #(num_entries * 64 * CLK_PERIOD);
        $display("timeout: the cache stopped answering requests, %0d errors so far", errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
dv/dcache_mem_model.sv
dv/tb_dcache.sv
